/* common/svf_coeff_table.svh */
// lowpass coefficients a1, a2 and a3 in Q4.31, one entry per group of eight notes
// entry 0 holds zeros so the lowest notes leave the integrators idle
`ifndef SVF_COEFF_TABLE_SVH
`define SVF_COEFF_TABLE_SVH

localparam coef_t COEF_A1 [TABLE_DEPTH] = '{
	35'h0_0000_0000,
	35'h0_7C01_B945,
	35'h0_7790_1274,
	35'h0_72A6_A1DC,
	35'h0_6D43_15C2,
	35'h0_6765_A196,
	35'h0_6111_4B5D,
	35'h0_5A4C_04C0,
	35'h0_531E_7B6F,
	35'h0_4B93_90D3,
	35'h0_43B7_7194,
	35'h0_3B96_5363,
	35'h0_333A_F513,
	35'h0_2AAD_2760,
	35'h0_21F1_16BC,
	35'h0_1909_934C
};

localparam coef_t COEF_A2 [TABLE_DEPTH] = '{
	35'h0_0000_0000,
	35'h0_01FB_1692,
	35'h0_0425_8E2F,
	35'h0_067D_A5D9,
	35'h0_08FF_996F,
	35'h0_0BA5_4ABE,
	35'h0_0E65_F9F4,
	35'h0_1136_137D,
	35'h0_1407_127E,
	35'h0_16C7_6A0D,
	35'h0_1962_4F61,
	35'h0_1BBF_155D,
	35'h0_1DBF_7A33,
	35'h0_1F3B_9D16,
	35'h0_1FF8_ADFD,
	35'h0_1F92_CCFE
};

// a3 grows fastest with the cutoff, it is g squared over m
localparam coef_t COEF_A3 [TABLE_DEPTH] = '{
	35'h0_0000_0000,
	35'h0_0008_1995,
	35'h0_0024_D12C,
	35'h0_005E_1270,
	35'h0_00BD_B75D,
	35'h0_014F_C8ED,
	35'h0_0222_C0B9,
	35'h0_0347_D445,
	35'h0_04D3_5F93,
	35'h0_06DD_9B11,
	35'h0_0983_EFA7,
	35'h0_0CEB_81E2,
	35'h0_1146_1685,
	35'h0_16DB_9E73,
	35'h0_1E1D_8D48,
	35'h0_27D0_D2B6
};

`endif

/* common/svf_pkg.sv */
// widths and fixed-point constants of the state variable lowpass filter
// sample, coefficient and sequencer state types, plus the per-note coefficient table
package svf_pkg;

	// audio and control widths
	localparam int SAMPLE_W     = 16;
	localparam int NOTE_W       = 7;

	// filter states and coefficients are signed Q4.31
	localparam int STATE_W      = 35;
	localparam int FRAC_W       = 31;

	// Q0.15 sample to Q4.31 state and back
	localparam int SAMPLE_SHIFT = 16;

	// full product width of two state words
	localparam int PROD_W       = 2 * STATE_W;

	// coefficient table is indexed by the upper note bits
	localparam int TABLE_IDX_W  = 4;
	localparam int TABLE_DEPTH  = 1 << TABLE_IDX_W;

	// output sample limits used by the saturation
	localparam int SAMPLE_MAX   = (2 ** (SAMPLE_W - 1)) - 1;
	localparam int SAMPLE_MIN   = -(2 ** (SAMPLE_W - 1));

	localparam logic [NOTE_W-1:0] MUTE_NOTE = 7'd0; // this note silences the output

	typedef logic signed [STATE_W-1:0]  coef_t;
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// each state names the phase whose result is held in the registers
	typedef enum logic [1:0] {
		idle,
		solve_v3,
		solve_v1v2,
		update_ic
	} seq_state_t;

	`include "svf_coeff_table.svh"

endpackage

/* filter/svf_coeff_decode.sv */
// decode stage of the lowpass filter
// accepts a sample strobe, looks up the coefficients and flags the mute note
`timescale 1ns/1ps

module svf_coeff_decode (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       i_sample_strobe,
	input  svf_pkg::sample_t           i_sample,
	input  logic [svf_pkg::NOTE_W-1:0] i_note,
	input  logic                       i_busy,
	output logic                       o_start,
	output svf_pkg::coef_t             o_a1,
	output svf_pkg::coef_t             o_a2,
	output svf_pkg::coef_t             o_a3,
	output svf_pkg::coef_t             o_v0,
	output logic                       o_mute
);
	import svf_pkg::*;

	logic                   accept;
	logic [TABLE_IDX_W-1:0] table_idx;
	coef_t                  v0_ext;

	// a strobe that arrives while a sample is in flight is dropped
	assign accept = i_sample_strobe && !i_busy && !o_start;

	assign table_idx = i_note[NOTE_W-1 -: TABLE_IDX_W];
	assign v0_ext    = coef_t'(i_sample); // sign extension into the state width

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_start <= 1'b0;
			o_mute  <= 1'b0;
		end else begin
			o_start <= accept;
			if (accept) begin
				o_mute <= (i_note == MUTE_NOTE); // held until the next accepted sample
			end
		end
	end

	// coefficients and v0 stay stable while execute works on them
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_a1 <= '0;
			o_a2 <= '0;
			o_a3 <= '0;
			o_v0 <= '0;
		end else if (accept) begin
			o_a1 <= COEF_A1[table_idx];
			o_a2 <= COEF_A2[table_idx];
			o_a3 <= COEF_A3[table_idx];
			o_v0 <= v0_ext <<< SAMPLE_SHIFT; // Q0.15 lands on the Q4.31 binary point
		end
	end

endmodule

/* filter/svf_integrator_execute.sv */
// execute stage of the lowpass filter
// three-phase trapezoidal integrator update with four signed products
`timescale 1ns/1ps

module svf_integrator_execute (
	input  logic           clk,
	input  logic           rst,
	input  logic           i_start,
	input  svf_pkg::coef_t i_a1,
	input  svf_pkg::coef_t i_a2,
	input  svf_pkg::coef_t i_a3,
	input  svf_pkg::coef_t i_v0,
	output svf_pkg::coef_t o_v2,
	output logic           o_done,
	output logic           o_busy
);
	import svf_pkg::*;

	seq_state_t state;

	// v1, v2 and v3 of the current sample
	coef_t v1;
	coef_t v2;
	coef_t v3;

	// integrator states carried from one sample to the next
	coef_t ic1eq;
	coef_t ic2eq;

	logic signed [PROD_W-1:0] p_a1_ic1;
	logic signed [PROD_W-1:0] p_a2_v3;
	logic signed [PROD_W-1:0] p_a2_ic1;
	logic signed [PROD_W-1:0] p_a3_v3;

	// one guard bit so the sum of two full products cannot wrap
	logic signed [PROD_W:0] sum_v1;
	logic signed [PROD_W:0] sum_v2;

	coef_t v1_next;
	coef_t v2_next;

	assign p_a1_ic1 = i_a1 * ic1eq;
	assign p_a2_v3  = i_a2 * v3;
	assign p_a2_ic1 = i_a2 * ic1eq;
	assign p_a3_v3  = i_a3 * v3;

	assign sum_v1 = p_a1_ic1 + p_a2_v3;
	assign sum_v2 = p_a2_ic1 + p_a3_v3;

	// Q8.62 sums go back to Q4.31 and the upper bits are dropped
	assign v1_next = coef_t'(sum_v1 >>> FRAC_W);
	assign v2_next = ic2eq + coef_t'(sum_v2 >>> FRAC_W);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= idle;
		end else begin
			case (state)
				idle: begin
					if (i_start) begin
						state <= solve_v3;
					end
				end
				solve_v3: begin
					state <= solve_v1v2;
				end
				solve_v1v2: begin
					state <= update_ic;
				end
				update_ic: begin
					state <= idle; // next sample may be offered from here on
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	// each phase is registered on the edge that enters the state of the same name
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			v1    <= '0;
			v2    <= '0;
			v3    <= '0;
			ic1eq <= '0;
			ic2eq <= '0;
		end else begin
			case (state)
				idle: begin
					if (i_start) begin
						v3 <= i_v0 - ic2eq;
					end
				end
				solve_v3: begin
					v1 <= v1_next;
					v2 <= v2_next;
				end
				solve_v1v2: begin
					ic1eq <= (v1 <<< 1) - ic1eq;
					ic2eq <= (v2 <<< 1) - ic2eq;
				end
			endcase
		end
	end

	assign o_v2   = v2;
	assign o_done = (state == update_ic);
	assign o_busy = (state != idle); // also high in the done cycle

endmodule

/* filter/svf_output_result.sv */
// result stage of the lowpass filter
// scales v2 to a saturated 16-bit sample, applies muting and pulses the strobe
`timescale 1ns/1ps

module svf_output_result (
	input  logic             clk,
	input  logic             rst,
	input  svf_pkg::coef_t   i_v2,
	input  logic             i_done,
	input  logic             i_mute,
	output svf_pkg::sample_t o_sample,
	output logic             o_sample_strobe
);
	import svf_pkg::*;

	// v2 with the extra fraction bits dropped, still carrying the integer part
	logic signed [STATE_W-SAMPLE_SHIFT-1:0] v2_scaled;
	sample_t                                sat_sample;

	assign v2_scaled = i_v2[STATE_W-1:SAMPLE_SHIFT];

	// a resonant peak can exceed full scale, so clip instead of wrapping
	always_comb begin
		if (v2_scaled > SAMPLE_MAX) begin
			sat_sample = sample_t'(SAMPLE_MAX);
		end else if (v2_scaled < SAMPLE_MIN) begin
			sat_sample = sample_t'(SAMPLE_MIN);
		end else begin
			sat_sample = v2_scaled[SAMPLE_W-1:0];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_sample        <= '0;
			o_sample_strobe <= 1'b0;
		end else begin
			o_sample_strobe <= i_done;
			if (i_done) begin
				o_sample <= i_mute ? '0 : sat_sample; // integrators keep running when muted
			end
		end
	end

endmodule

/* logic/svf_lowpass_top.sv */
// top level of the state variable lowpass filter
// decode, execute and result stages, one sample in flight at a time
`timescale 1ns/1ps

module svf_lowpass_top (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       i_sample_strobe,
	input  svf_pkg::sample_t           i_sample,
	input  logic [svf_pkg::NOTE_W-1:0] i_note,
	output svf_pkg::sample_t           o_sample,
	output logic                       o_sample_strobe
);
	import svf_pkg::*;

	logic  start;
	logic  busy;
	logic  done;
	logic  mute;
	coef_t a1;
	coef_t a2;
	coef_t a3;
	coef_t v0;
	coef_t v2;

	svf_coeff_decode u_decode (
		.clk             (clk),
		.rst             (rst),
		.i_sample_strobe (i_sample_strobe),
		.i_sample        (i_sample),
		.i_note          (i_note),
		.i_busy          (busy),
		.o_start         (start),
		.o_a1            (a1),
		.o_a2            (a2),
		.o_a3            (a3),
		.o_v0            (v0),
		.o_mute          (mute)
	);

	svf_integrator_execute u_execute (
		.clk     (clk),
		.rst     (rst),
		.i_start (start),
		.i_a1    (a1),
		.i_a2    (a2),
		.i_a3    (a3),
		.i_v0    (v0),
		.o_v2    (v2),
		.o_done  (done),
		.o_busy  (busy)
	);

	svf_output_result u_result (
		.clk             (clk),
		.rst             (rst),
		.i_v2            (v2),
		.i_done          (done),
		.i_mute          (mute),
		.o_sample        (o_sample),
		.o_sample_strobe (o_sample_strobe)
	);

endmodule

/* sim/svf_tb.sv */
// self-checking testbench for the state variable lowpass filter
// reference model with the package coefficient table, LCG stimulus and clocked assertions
`timescale 1ns/1ps

module svf_tb;
	import svf_pkg::*;

	localparam int WAIT_LIMIT = 20;
	localparam int LATENCY    = 5;
	localparam int DC_LEVEL   = 16000;
	localparam int DC_BOUND   = 32;   // final DC output may differ from the input by this much

	logic              clk;
	logic              rst;
	logic              i_sample_strobe;
	sample_t           i_sample;
	logic [NOTE_W-1:0] i_note;
	sample_t           o_sample;
	logic              o_sample_strobe;

	logic [31:0] lcg_state = 32'h6ca7;
	int          error_count = 0;
	int          check_count = 0;
	int          test_count = 0;
	int          test_errors_start = 0;
	int          test_checks_start = 0;

	// reference model state
	coef_t       m_ic1 = '0;
	coef_t       m_ic2 = '0;
	sample_t     exp_out = '0;
	sample_t     last_out = '0;
	sample_t     last_seen = '0;
	logic [4:0]  pipe = '0;   // accepted strobes of the last five edges
	int          block_cnt = 0;
	bit          accepted;

	svf_lowpass_top DUT (
		.clk             (clk),
		.rst             (rst),
		.i_sample_strobe (i_sample_strobe),
		.i_sample        (i_sample),
		.i_note          (i_note),
		.o_sample        (o_sample),
		.o_sample_strobe (o_sample_strobe)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// one trapezoidal step of the model that also advances its integrator states
	function automatic sample_t model_step(input sample_t s, input logic [NOTE_W-1:0] note);
		logic [TABLE_IDX_W-1:0] idx;
		coef_t                  a1;
		coef_t                  a2;
		coef_t                  a3;
		coef_t                  v0;
		coef_t                  v1;
		coef_t                  v2;
		coef_t                  v3;
		logic signed [PROD_W:0] s1;
		logic signed [PROD_W:0] s2;
		longint                 y;
		idx = note[NOTE_W-1 -: TABLE_IDX_W];
		a1 = COEF_A1[idx];
		a2 = COEF_A2[idx];
		a3 = COEF_A3[idx];
		v0 = coef_t'(s) <<< SAMPLE_SHIFT;
		v3 = v0 - m_ic2;
		s1 = a1 * m_ic1 + a2 * v3;
		s2 = a2 * m_ic1 + a3 * v3;
		v1 = coef_t'(s1 >>> FRAC_W);
		v2 = m_ic2 + coef_t'(s2 >>> FRAC_W);
		m_ic1 = 2 * v1 - m_ic1;
		m_ic2 = 2 * v2 - m_ic2;
		y = longint'(v2) >>> SAMPLE_SHIFT;
		if (note == MUTE_NOTE) begin
			y = 0;
		end else if (y > SAMPLE_MAX) begin
			y = SAMPLE_MAX;
		end else if (y < SAMPLE_MIN) begin
			y = SAMPLE_MIN;
		end
		return sample_t'(y);
	endfunction

	// follows acceptance and runs the model on each accepted strobe
	always @(posedge clk) begin
		if (rst) begin
			pipe = '0;
			block_cnt = 0;
			m_ic1 = '0;
			m_ic2 = '0;
			last_out = '0;
		end else begin
			if (o_sample_strobe) begin
				check_count++;
				last_out = exp_out;
			end
			accepted = i_sample_strobe && (block_cnt == 0);
			pipe = {pipe[LATENCY-2:0], accepted};
			if (accepted) begin
				exp_out = model_step(i_sample, i_note);
				block_cnt = LATENCY - 1;
			end else if (block_cnt > 0) begin
				block_cnt--;
			end
		end
	end

	assert property (@(posedge clk) rst || (o_sample_strobe == pipe[LATENCY-1])) else begin
		$display("o_sample_strobe does not come exactly 5 cycles after an accepted strobe");
		error_count++;
	end

	assert property (@(posedge clk) rst || !o_sample_strobe || (o_sample == exp_out)) else begin
		$display("mismatch o_sample: got 0x%h expected 0x%h",
			$sampled(o_sample), $sampled(exp_out));
		error_count++;
	end

	// between output strobes the last sample is held
	assert property (@(posedge clk) rst || o_sample_strobe || (o_sample == last_out)) else begin
		$display("mismatch o_sample (idle): got 0x%h expected 0x%h",
			$sampled(o_sample), $sampled(last_out));
		error_count++;
	end

	// offers one sample, optionally with a second strobe that must be dropped
	task automatic send_sample(input sample_t s, input logic [NOTE_W-1:0] note, input bit with_drop);
		int n;
		i_sample <= s;
		i_note <= note;
		i_sample_strobe <= 1'b1;
		@(posedge clk);
		i_sample_strobe <= 1'b0;
		n = 0;
		if (with_drop) begin
			@(posedge clk);
			i_sample <= ~s;
			i_note <= 7'd127;
			i_sample_strobe <= 1'b1;
			@(posedge clk);
			i_sample_strobe <= 1'b0;
			n = 2;
		end
		do begin
			@(posedge clk);
			n++;
		end while (!o_sample_strobe && n < WAIT_LIMIT);
		if (!o_sample_strobe) begin
			$display("timeout: no o_sample_strobe within %0d cycles of a strobe", WAIT_LIMIT);
			error_count++;
		end else begin
			assert (n == LATENCY) else begin
				$display("o_sample_strobe came %0d cycles after the strobe instead of 5", n);
				error_count++;
			end
			last_seen = o_sample;
		end
	endtask

	task automatic start_test();
		test_errors_start = error_count;
		test_checks_start = check_count;
	endtask

	task automatic end_test(input string name);
		test_count++;
		$display("test %-14s %0d checks, %0d errors", name,
			check_count - test_checks_start, error_count - test_errors_start);
	endtask

	initial begin
		logic [NOTE_W-1:0] notes [4];
		int                dc_err;
		notes = '{7'd24, 7'd48, 7'd72, 7'd100};
		rst = 1'b1;
		i_sample_strobe = 1'b0;
		i_sample = '0;
		i_note = '0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		start_test();
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			check_count++;
			assert (o_sample == '0) else begin
				$display("mismatch o_sample after reset: got 0x%h expected 0x0000", o_sample);
				error_count++;
			end
			assert (!o_sample_strobe) else begin
				$display("o_sample_strobe pulsed after reset without a strobe");
				error_count++;
			end
		end
		end_test("reset_state");

		start_test();
		for (int i = 0; i < 8; i++) begin
			send_sample(sample_t'(lcg_next() >> 16), 7'd64, 1'b0);
		end
		end_test("latency");

		start_test();
		for (int i = 0; i < 200; i++) begin
			send_sample(sample_t'(lcg_next() >> 16), notes[(i / 50) % 4], 1'b0);
		end
		end_test("filter_values");

		start_test();
		for (int i = 0; i < 100; i++) begin
			send_sample(sample_t'(DC_LEVEL), 7'd64, 1'b0);
		end
		dc_err = int'(last_seen) - DC_LEVEL;
		assert (dc_err <= DC_BOUND && dc_err >= -DC_BOUND) else begin
			$display("dc step settled at %0d, more than %0d away from %0d",
				last_seen, DC_BOUND, DC_LEVEL);
			error_count++;
		end
		end_test("dc_step");

		start_test();
		for (int i = 0; i < 10; i++) begin
			send_sample(sample_t'(lcg_next() >> 16), MUTE_NOTE, 1'b0);
		end
		for (int i = 0; i < 20; i++) begin
			send_sample(sample_t'(lcg_next() >> 16), 7'd96, 1'b0);
		end
		end_test("mute");

		start_test();
		for (int i = 0; i < 5; i++) begin
			send_sample(sample_t'(lcg_next() >> 16), 7'd72, 1'b1);
			send_sample(sample_t'(lcg_next() >> 16), 7'd72, 1'b0);
			send_sample(sample_t'(lcg_next() >> 16), 7'd72, 1'b0);
		end
		end_test("dropped_strobe");

		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
		if (error_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* files.f */
+incdir+common
common/svf_pkg.sv
filter/svf_coeff_decode.sv
filter/svf_integrator_execute.sv
filter/svf_output_result.sv
logic/svf_lowpass_top.sv
sim/svf_tb.sv
